// File: fetch_pkg.sv
package fetch_pkg;

   // core side widths
   localparam int XLEN = 64;
   localparam int ILEN = 32;
   localparam int WLEN = 64;

   // byte address as the core sees it
   typedef logic [XLEN-1:0] addr_t;
   // one instruction
   typedef logic [ILEN-1:0] inst_t;
   // one memory word, holds two instructions
   typedef logic [WLEN-1:0] word_t;

   // boot address
   localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

   // sequential step, no compressed instructions
   localparam addr_t INST_BYTES = 64'd4;

   // fetch fsm, one request in flight at most
   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_REQUEST,
      FETCH_WAIT
   } fetch_state_t;

endpackage

// File: bus_pkg.sv
package bus_pkg;

   // memory geometry in 64-bit words
   localparam int MEM_WORDS  = 1024;
   localparam int WORD_BYTES = 8;
   localparam int IDX_W      = $clog2(MEM_WORDS);

   // byte address of word 0, matches the boot pc
   localparam logic [63:0] MEM_BASE = 64'h0000_0000_8000_0000;
   // first byte past the array
   localparam logic [63:0] MEM_END  = MEM_BASE + MEM_WORDS * WORD_BYTES;

   // accept edge to rvalid, in cycles
   localparam int MEM_LATENCY = 3;
   localparam int LAT_W       = $clog2(MEM_LATENCY + 1);

   typedef logic [IDX_W-1:0] widx_t;
   typedef logic [LAT_W-1:0] lat_cnt_t;

   // read response
   typedef logic resp_t;
   localparam resp_t RESP_OKAY = 1'b0;
   localparam resp_t RESP_ERR  = 1'b1;

   typedef enum logic {MEM_READY, MEM_BUSY} mem_state_t;

endpackage

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   // one pulse per completed fetch
   input  logic  fetch_done,
   // branch target from later stages
   input  logic  redirect_valid,
   input  addr_t redirect_pc,
   output addr_t pc
);

   // current fetch address
   addr_t pc_q;
   // redirect seen since the last completion
   logic  pend_q;
   addr_t pend_pc_q;
   // candidate for the next fetch
   addr_t pc_next;

   // simultaneous redirect beats the pending one
   // pending one beats the sequential step
   always_comb begin
      if (redirect_valid) begin
         pc_next = redirect_pc;
      end else if (pend_q) begin
         pc_next = pend_pc_q;
      end else begin
         pc_next = pc_q + INST_BYTES;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q   <= RESET_PC;
         pend_q <= 1'b0;
      end else begin
         if (fetch_done) begin
            // pc only moves between fetches
            pc_q   <= pc_next;
            pend_q <= 1'b0;
         end else if (redirect_valid) begin
            pend_q <= 1'b1;
         end
      end
   end

   // target register, the last redirect wins
   // only read while pend_q is set
   always_ff @(posedge clk) begin
      if (redirect_valid) begin
         pend_pc_q <= redirect_pc;
      end
   end

   assign pc = pc_q;

endmodule

// File: ifu.sv
`timescale 1ns/1ps

module ifu
   import fetch_pkg::*, bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // sampled in idle only
   input  logic        stall,
   input  addr_t       pc,
   // read address channel
   output logic        arvalid,
   output logic [31:0] araddr,
   input  logic        arready,
   // read data channel, no ready
   input  logic        rvalid,
   input  word_t       rdata,
   input  resp_t       rresp,
   // fetched instruction
   output inst_t       inst,
   output addr_t       inst_pc,
   output logic        inst_valid,
   output logic        inst_err,
   // completion pulse to pc_gen
   output logic        fetch_done
);

   fetch_state_t state_q;
   fetch_state_t state_d;

   // address handshake this cycle
   logic  accept;
   // response taken this cycle
   logic  resp_take;
   logic  resp_err;
   // instruction slot picked from the word
   inst_t half;
   // registered completion
   logic  done_q;

   // arvalid held for the whole request state
   assign arvalid = (state_q == FETCH_REQUEST);
   // zero address outside a request
   assign araddr  = arvalid ? pc[31:0] : 32'b0;
   assign accept  = arvalid && arready;

   assign resp_take = rvalid && (state_q == FETCH_WAIT);
   assign resp_err  = (rresp == RESP_ERR);

   // pc[2] picks the upper instruction of the word
   assign half = pc[2] ? rdata[63:32] : rdata[31:0];

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH_IDLE: begin
            // back-pressure only holds off new requests
            if (!stall) begin
               state_d = FETCH_REQUEST;
            end
         end
         FETCH_REQUEST: begin
            if (accept) begin
               state_d = FETCH_WAIT;
            end
         end
         FETCH_WAIT: begin
            // accepted request always completes
            if (rvalid) begin
               state_d = FETCH_IDLE;
            end
         end
         default: begin
            state_d = FETCH_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= FETCH_IDLE;
         done_q   <= 1'b0;
         inst_err <= 1'b0;
         inst     <= '0;
      end else begin
         state_q <= state_d;
         done_q  <= resp_take;
         if (resp_take) begin
            inst_err <= resp_err;
            // no stale data on a bus error
            inst     <= resp_err ? '0 : half;
         end
      end
   end

   // pc is stable until fetch_done, safe to sample here
   always_ff @(posedge clk) begin
      if (resp_take) begin
         inst_pc <= pc;
      end
   end

   // same pulse to the next stage and to pc_gen
   assign inst_valid = done_q;
   assign fetch_done = done_q;

endmodule

// File: imem.sv
`timescale 1ns/1ps

module imem
   import fetch_pkg::*, bus_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // read address channel
   input  logic        arvalid,
   input  logic [31:0] araddr,
   output logic        arready,
   // read data channel
   output logic        rvalid,
   output word_t       rdata,
   output resp_t       rresp,
   // preload port
   input  logic        load_en,
   input  widx_t       load_addr,
   input  word_t       load_data
);

   // instruction storage
   word_t mem [MEM_WORDS];

   mem_state_t state_q;
   lat_cnt_t   cnt_q;
   // address captured on accept
   logic [31:0] addr_q;

   logic  accept;
   logic  done;
   logic  hit;
   widx_t idx;

   // ready whenever nothing is outstanding
   assign arready = (state_q == MEM_READY);
   assign accept  = arvalid && arready;
   // last latency cycle
   assign done    = (state_q == MEM_BUSY) && (cnt_q == '0);

   // range check on the captured address
   assign hit = ({32'b0, addr_q} >= MEM_BASE) && ({32'b0, addr_q} < MEM_END);
   // base is aligned to the array size, so no offset subtract
   assign idx = addr_q[12:3];

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= MEM_READY;
         cnt_q   <= '0;
         rvalid  <= 1'b0;
      end else begin
         // single cycle strobe
         rvalid <= 1'b0;
         case (state_q)
            MEM_READY: begin
               if (accept) begin
                  state_q <= MEM_BUSY;
                  cnt_q   <= lat_cnt_t'(MEM_LATENCY - 1);
               end
            end
            MEM_BUSY: begin
               if (done) begin
                  state_q <= MEM_READY;
                  rvalid  <= 1'b1;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: begin
               state_q <= MEM_READY;
            end
         endcase
      end
   end

   // request address
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= araddr;
      end
   end

   // read data lands with rvalid
   // out of range gives zero data and an error
   always_ff @(posedge clk) begin
      if (done) begin
         rdata <= hit ? mem[idx] : '0;
         rresp <= hit ? RESP_OKAY : RESP_ERR;
      end
   end

   // preload write
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top
   import fetch_pkg::*, bus_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   // hold off new fetches
   input  logic  stall,
   // branch target from later stages
   input  logic  redirect_valid,
   input  addr_t redirect_pc,
   // memory preload
   input  logic  load_en,
   input  widx_t load_addr,
   input  word_t load_data,
   // fetched instruction
   output inst_t inst,
   output addr_t inst_pc,
   output logic  inst_valid,
   output logic  inst_err
);

   // pc to the fetch unit
   addr_t       pc;
   logic        fetch_done;

   // fetch unit to memory
   logic        arvalid;
   logic [31:0] araddr;
   logic        arready;
   logic        rvalid;
   word_t       rdata;
   resp_t       rresp;

   pc_gen u_pc_gen (
      .clk            (clk),
      .rst            (rst),
      .fetch_done     (fetch_done),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .pc             (pc)
   );

   ifu u_ifu (
      .clk        (clk),
      .rst        (rst),
      .stall      (stall),
      .pc         (pc),
      .arvalid    (arvalid),
      .araddr     (araddr),
      .arready    (arready),
      .rvalid     (rvalid),
      .rdata      (rdata),
      .rresp      (rresp),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid),
      .inst_err   (inst_err),
      .fetch_done (fetch_done)
   );

   imem u_imem (
      .clk       (clk),
      .rst       (rst),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arready   (arready),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top
   import fetch_pkg::*, bus_pkg::*;
();

   localparam int SEED          = 20987;
   localparam int RESET_CYCLES  = 16;
   // accept, latency, response register, pc update
   localparam int FETCH_GAP     = MEM_LATENCY + 3;
   localparam int N_SEQ         = 40;
   localparam int N_REDIR       = 60;
   localparam int N_STALLS      = 4;
   localparam int N_AFTER_STALL = 4;
   localparam int N_ERR         = 5;
   localparam int N_BACK        = 6;
   localparam int STALL_MAX     = 24;
   localparam int TOTAL_FETCHES = N_SEQ + N_REDIR + N_STALLS * N_AFTER_STALL + N_ERR + N_BACK;
   localparam int MARGIN        = 400;
   localparam int TIMEOUT_CYCLES = MEM_WORDS + RESET_CYCLES + TOTAL_FETCHES * FETCH_GAP
                                   + N_STALLS * (STALL_MAX + FETCH_GAP) + MARGIN;
   // end of the mapped window, base plus eight bytes per word
   localparam addr_t MODEL_END  = MEM_BASE + MEM_WORDS * 8;

   logic  clk;
   logic  rst;
   logic  stall;
   logic  redirect_valid;
   addr_t redirect_pc;
   logic  load_en;
   widx_t load_addr;
   word_t load_data;
   inst_t inst;
   addr_t inst_pc;
   logic  inst_valid;
   logic  inst_err;

   // mirror of the preloaded memory
   word_t model_mem [MEM_WORDS];

   // pc model
   addr_t exp_pc;
   logic  pend;
   addr_t pend_pc;

   // monitor bookkeeping
   logic  seen_reset;
   int    cyc;
   int    last_valid_cyc;
   logic  stall_in_gap;
   int    stall_valids;
   int    fetch_cnt;

   int    value_errs;
   int    timing_errs;
   int    stall_errs;
   int    rnd_seed;

   fetch_top DUT (
      .clk            (clk),
      .rst            (rst),
      .stall          (stall),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .load_en        (load_en),
      .load_addr      (load_addr),
      .load_data      (load_data),
      .inst           (inst),
      .inst_pc        (inst_pc),
      .inst_valid     (inst_valid),
      .inst_err       (inst_err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // aligned target inside the memory window
   function automatic addr_t in_range_target();
      return MEM_BASE + addr_t'(($urandom % (MEM_WORDS * 2)) * 4);
   endfunction

   // well clear of the window, stays outside after many steps
   function automatic addr_t far_target();
      return 64'h0000_0000_9000_0000 + addr_t'(($urandom % 64) * 4);
   endfunction

   task automatic preload_memory();
      word_t w;
      for (int i = 0; i < MEM_WORDS; i++) begin
         w = {$urandom, $urandom};
         @(posedge clk);
         load_en      <= 1'b1;
         load_addr    <= widx_t'(i);
         load_data    <= w;
         model_mem[i] = w;
      end
   endtask

   // keep driving until n more completions are seen
   task automatic run_fetches(input int n, input int redir_pct);
      int target;
      target = fetch_cnt + n;
      while (fetch_cnt < target) begin
         @(posedge clk);
         if (($urandom % 100) < redir_pct) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= in_range_target();
         end else begin
            redirect_valid <= 1'b0;
         end
      end
   endtask

   task automatic redirect_once(input addr_t target);
      @(posedge clk);
      redirect_valid <= 1'b1;
      redirect_pc    <= target;
      @(posedge clk);
      redirect_valid <= 1'b0;
   endtask

   task automatic hold_stall(input int cycles);
      @(posedge clk);
      stall          <= 1'b1;
      redirect_valid <= 1'b0;
      repeat (cycles) @(posedge clk);
      stall <= 1'b0;
   endtask

   // compare one completed fetch against the memory model
   task automatic check_fetch();
      logic  hit;
      word_t w;
      inst_t exp_inst;
      hit      = (exp_pc >= MEM_BASE) && (exp_pc < MODEL_END);
      w        = hit ? model_mem[(exp_pc - MEM_BASE) >> 3] : '0;
      exp_inst = !hit ? '0 : (exp_pc[2] ? w[63:32] : w[31:0]);
      assert (inst_pc == exp_pc) else begin
         value_errs++;
         $display("Fail %0t: inst_pc %h, expected %h", $time, inst_pc, exp_pc);
      end
      assert (inst_err == !hit) else begin
         value_errs++;
         $display("Fail %0t: inst_err %b at pc %h, expected %b", $time, inst_err, exp_pc, !hit);
      end
      assert (inst == exp_inst) else begin
         value_errs++;
         $display("Fail %0t: inst %h at pc %h, expected %h", $time, inst, exp_pc, exp_inst);
      end
   endtask

   // spacing only fixed when stall stayed low
   task automatic check_gap();
      int exp_cyc;
      exp_cyc = (last_valid_cyc == 0) ? FETCH_GAP + 1 : last_valid_cyc + FETCH_GAP;
      if (!stall_in_gap) begin
         assert (cyc == exp_cyc) else begin
            timing_errs++;
            $display("Fail %0t: inst_valid at cycle %0d, expected cycle %0d",
                     $time, cyc, exp_cyc);
         end
      end
   endtask

   // samples pre-edge values, same as the DUT sees them
   always @(posedge clk) begin
      if (rst) begin
         seen_reset     = 1'b1;
         cyc            = 0;
         last_valid_cyc = 0;
         stall_in_gap   = 1'b0;
         stall_valids   = 0;
         exp_pc         = RESET_PC;
         pend           = 1'b0;
      end else if (seen_reset) begin
         cyc = cyc + 1;
         if (inst_valid) begin
            check_fetch();
            check_gap();
            fetch_cnt <= fetch_cnt + 1;
            // redirect in the completion cycle wins, then pending, then step
            if (redirect_valid) begin
               exp_pc = redirect_pc;
            end else if (pend) begin
               exp_pc = pend_pc;
            end else begin
               exp_pc = exp_pc + INST_BYTES;
            end
            pend           = 1'b0;
            last_valid_cyc = cyc;
            // idle samples stall on this same edge
            stall_in_gap   = stall;
         end else begin
            if (redirect_valid) begin
               pend    = 1'b1;
               pend_pc = redirect_pc;
            end
            stall_in_gap = stall_in_gap | stall;
         end
         // only the fetch in flight may finish under stall
         if (stall) begin
            if (inst_valid) begin
               stall_valids++;
            end
            assert (stall_valids <= 1) else begin
               stall_errs++;
               $display("Fail %0t: %0d fetches completed during one stall", $time, stall_valids);
            end
         end else begin
            stall_valids = 0;
         end
      end
   end

   task automatic print_counts();
      $display("error counts: value %0d, timing %0d, stall %0d",
               value_errs, timing_errs, stall_errs);
   endtask

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("run timed out after %0d cycles, fetch stream stopped", TIMEOUT_CYCLES);
      print_counts();
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rst            = 1'b0;
      stall          = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc    = '0;
      load_en        = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      seen_reset     = 1'b0;
      fetch_cnt      = 0;
      value_errs     = 0;
      timing_errs    = 0;
      stall_errs     = 0;
      rnd_seed       = SEED;
      void'($urandom(rnd_seed));

      // memory fill ahead of the reset pulse
      preload_memory();
      @(posedge clk);
      load_en <= 1'b0;
      rst     <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // straight line code
      run_fetches(N_SEQ, 0);
      // frequent redirects, often several per fetch
      run_fetches(N_REDIR, 20);
      // stall at random offsets within a fetch
      for (int k = 0; k < N_STALLS; k++) begin
         repeat ($urandom % FETCH_GAP) @(posedge clk);
         hold_stall(FETCH_GAP + 2 + ($urandom % (STALL_MAX - FETCH_GAP - 2)));
         run_fetches(N_AFTER_STALL, 0);
      end
      // out of range, then back into the window
      redirect_once(far_target());
      run_fetches(N_ERR, 0);
      redirect_once(in_range_target());
      run_fetches(N_BACK, 0);
      repeat (2) @(posedge clk);

      print_counts();
      if (value_errs + timing_errs + stall_errs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: fetch_top.f
fetch_pkg.sv
bus_pkg.sv
pc_gen.sv
ifu.sv
imem.sv
fetch_top.sv
tb_fetch_top.sv
